// ==== Bender.yml ====
package:
  name: cacheCtl

sources:
  - hdl/cachePkg.sv
  - hdl/cacheArbiter.sv
  - hdl/wayMatch.sv
  - hdl/cacheSequencer.sv
  - hdl/cacheCtl.sv
  - target: test
    files:
      - verification/cacheCtl_checker.sv
      - verification/cacheCtl_tb.sv

// ==== cacheCtl.f ====
hdl/cachePkg.sv
hdl/cacheArbiter.sv
hdl/wayMatch.sv
hdl/cacheSequencer.sv
hdl/cacheCtl.sv
verification/cacheCtl_checker.sv
verification/cacheCtl_tb.sv

// ==== verification/cacheCtl_tb.sv ====
`timescale 1ns/1ps

module cacheCtl_tb
  import cachePkg::*;
();

  localparam int NumWays = 4;
  localparam int ClkPeriod = 40;
  localparam int Seed = 94929;
  localparam int NumReads = 24;
  localparam int NumWrites = 24;
  localparam int NumCca = 16;
  localparam int NumTrans = 4 + NumReads + NumWrites + 3 + NumCca;
  localparam int TimeoutCycles = NumTrans * 20 + 50;

  typedef wayStat_t [NumWays-1:0] waySet_t;

  logic        clk;
  logic        rst;
  reqVec_t     req;
  eboxOp_t     eboxOp;
  waySet_t     ways;
  logic [1:0]  lru;
  logic        coreDone;
  reqVec_t     grant;
  logic        readyToGo;
  logic        coreRdReq;
  resp_t       resp;
  logic [1:0]  respWay;
  reqVec_t     pending;
  int unsigned lcgState;

  cacheCtl dut0 (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .eboxOp    (eboxOp),
    .ways      (ways),
    .lru       (lru),
    .coreDone  (coreDone),
    .grant     (grant),
    .readyToGo (readyToGo),
    .coreRdReq (coreRdReq),
    .resp      (resp),
    .respWay   (respWay)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial begin
    repeat (TimeoutCycles) @(posedge clk);
    $display("Timeout: tests did not finish within %0d cycles", TimeoutCycles);
    $display("Testbench failed");
    $fatal(1);
  end

  always @(negedge clk) begin
    if (dut0.chk0.failCount != 0) begin
      failNow("a bound assertion on the DUT ports failed");
    end
  end

  task automatic failNow(input string why);
    $display("Error at %0t: %s", $time, why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  function automatic int unsigned nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState >> 8;
  endfunction

  // Roughly one way in four matches
  function automatic waySet_t randomWays();
    waySet_t     w;
    int unsigned r;
    for (int i = 0; i < NumWays; i++) begin
      r = nextRand();
      w[i].validMatch = (r[1:0] == 2'b00);
      w[i].wordValid = r[2];
      w[i].anyWritten = r[3];
    end
    return w;
  endfunction

  // MB is the top bit of the request vector
  function automatic reqVec_t reqOf(input cycType_t c);
    return reqVec_t'(4'b1000 >> (int'(c) - 1));
  endfunction

  function automatic logic [1:0] pickWay(input waySet_t w, input logic [1:0] l);
    for (int i = 0; i < NumWays; i++) begin
      if (w[i].validMatch) begin
        return 2'(i);
      end
    end
    return l;
  endfunction

  function automatic outcome_t predictOutcome(input cycType_t c, input eboxOp_t op,
                                              input waySet_t w, input logic [1:0] l);
    logic anyMatch;
    logic found;
    anyMatch = 1'b0;
    found = 1'b0;
    for (int i = 0; i < NumWays; i++) begin
      anyMatch |= w[i].validMatch;
      found |= w[i].validMatch & w[i].wordValid;
    end
    case (c)
      CYC_EBOX: begin
        if (op == OP_READ) begin
          return found ? OUT_READ_HIT : OUT_READ_FILL;
        end
        if (anyMatch) begin
          return OUT_WRITE_HIT;
        end
        return w[l].anyWritten ? OUT_WRITEBACK : OUT_WRITE_ALLOC;
      end
      CYC_CCA: begin
        if (!anyMatch) begin
          return OUT_NO_MATCH;
        end
        return w[pickWay(w, l)].anyWritten ? OUT_WRITEBACK : OUT_INVAL;
      end
      default: return OUT_PASS;
    endcase
  endfunction

  // Ends on the grant edge with the granted request dropped
  task automatic waitGrant(input reqVec_t expected);
    int      waited;
    reqVec_t got;
    waited = 0;
    @(negedge clk);
    while (grant == '0) begin
      waited++;
      if (waited > 30) begin
        failNow("no grant while a request was pending");
      end
      @(negedge clk);
    end
    got = grant;
    checkEq(got, expected, "grant");
    @(posedge clk);
    pending = pending & ~got;
    req <= pending;
  endtask

  task automatic expectResp(input cycType_t expCyc, input outcome_t expOut,
                            input logic [1:0] expWay, input int coreDelay);
    int   lat;
    int   expLat;
    logic fill;
    logic seen;
    lat = 0;
    seen = 1'b0;
    fill = (expOut == OUT_READ_FILL);
    // Fill: coreDone comes coreDelay cycles after T3, the response one cycle later
    expLat = fill ? 4 + coreDelay : 3;
    while (!seen) begin
      @(negedge clk);
      lat++;
      seen = resp.valid;
      if (!seen) begin
        checkEq(readyToGo, 1'b0, "readyToGo while a cycle is in flight");
        checkEq(coreRdReq, fill && (lat >= 3), "coreRdReq");
        if (lat > 20) begin
          failNow("no response from the DUT after a grant");
        end
        @(posedge clk);
        coreDone <= fill && (lat == 2 + coreDelay);
      end
    end
    checkEq(lat, expLat, "cycles from grant to resp.valid");
    checkEq(resp.cycle, expCyc, "resp.cycle");
    checkEq(resp.outcome, expOut, "resp.outcome");
    checkEq(coreRdReq, 1'b0, "coreRdReq with resp.valid");
    if (expOut != OUT_PASS) begin
      checkEq(respWay, expWay, "respWay");
    end
  endtask

  task automatic runOne(input cycType_t c, input eboxOp_t op, input waySet_t w,
                        input logic [1:0] l, input int coreDelay);
    @(posedge clk);
    pending = reqOf(c);
    req <= pending;
    eboxOp <= op;
    ways <= w;
    lru <= l;
    waitGrant(reqOf(c));
    expectResp(c, predictOutcome(c, op, w, l), pickWay(w, l), coreDelay);
  endtask

  task automatic randomRun(input cycType_t c, input eboxOp_t op);
    waySet_t    w;
    logic [1:0] l;
    int         delay;
    w = randomWays();
    l = 2'(nextRand());
    delay = nextRand() % 8;
    runOne(c, op, w, l, delay);
  endtask

  task automatic resetTest();
    @(negedge clk);
    checkEq(readyToGo, 1'b1, "readyToGo after reset");
    checkEq(grant, '0, "grant after reset");
    checkEq(resp.valid, 1'b0, "resp.valid after reset");
    checkEq(coreRdReq, 1'b0, "coreRdReq after reset");
  endtask

  task automatic priorityTest();
    waySet_t    w;
    logic [1:0] l;
    w = randomWays();
    l = 2'(nextRand());
    @(posedge clk);
    pending = '1;
    req <= pending;
    eboxOp <= OP_WRITE;
    ways <= w;
    lru <= l;
    for (int c = int'(CYC_MB); c <= int'(CYC_CCA); c++) begin
      waitGrant(reqOf(cycType_t'(c)));
      expectResp(cycType_t'(c), predictOutcome(cycType_t'(c), OP_WRITE, w, l),
                 pickWay(w, l), 0);
    end
  endtask

  task automatic ccaTest();
    waySet_t w;
    // Written match on way 1
    w = '0;
    w[1] = 3'b101;
    runOne(CYC_CCA, OP_READ, w, 2'd0, 0);
    // Clean way 2 wins over written way 3
    w = '0;
    w[2] = 3'b110;
    w[3] = 3'b101;
    runOne(CYC_CCA, OP_READ, w, 2'd0, 0);
    w = '0;
    w[3] = 3'b011;
    runOne(CYC_CCA, OP_READ, w, 2'd3, 0);
    for (int i = 0; i < NumCca; i++) begin
      randomRun(CYC_CCA, OP_READ);
    end
  endtask

  initial begin
    lcgState = Seed;
    rst = 1'b1;
    req = '0;
    eboxOp = OP_READ;
    ways = '0;
    lru = '0;
    coreDone = 1'b0;
    pending = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    resetTest();
    priorityTest();
    for (int i = 0; i < NumReads; i++) begin
      randomRun(CYC_EBOX, OP_READ);
    end
    for (int i = 0; i < NumWrites; i++) begin
      randomRun(CYC_EBOX, OP_WRITE);
    end
    ccaTest();
    repeat (2) @(posedge clk);
    if (dut0.chk0.failCount == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("Testbench failed");
      $fatal(1);
    end
  end

endmodule

// ==== verification/cacheCtl_checker.sv ====
`timescale 1ns/1ps

module cacheCtl_checker
  import cachePkg::*;
(
  input logic    clk,
  input logic    rst,
  input reqVec_t grant,
  input logic    readyToGo,
  input logic    coreRdReq,
  input logic    coreDone,
  input resp_t   resp
);

  int failCount;

  initial failCount = 0;

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else begin
      failCount++;
      $error("grant has more than one bit set");
    end

  grantOnlyWhenReady: assert property (@(posedge clk) disable iff (rst)
    (grant != '0) |-> readyToGo)
    else begin
      failCount++;
      $error("grant issued while the sequencer was busy");
    end

  // Busy outputs never overlap with idle
  busyNotReady: assert property (@(posedge clk) disable iff (rst)
    (resp.valid || coreRdReq) |-> !readyToGo)
    else begin
      failCount++;
      $error("resp.valid or coreRdReq seen with readyToGo high");
    end

  coreRdHeld: assert property (@(posedge clk) disable iff (rst)
    (coreRdReq && !coreDone) |=> coreRdReq)
    else begin
      failCount++;
      $error("coreRdReq dropped before coreDone");
    end

endmodule

bind cacheCtl cacheCtl_checker chk0 (
  .clk       (clk),
  .rst       (rst),
  .grant     (grant),
  .readyToGo (readyToGo),
  .coreRdReq (coreRdReq),
  .coreDone  (coreDone),
  .resp      (resp)
);

// ==== hdl/cacheCtl.sv ====
`timescale 1ns/1ps

module cacheCtl
  import cachePkg::*;
#(
  parameter int NumWays = 4,
  localparam int WayW = (NumWays > 1) ? $clog2(NumWays) : 1
) (
  input  logic                     clk,
  input  logic                     rst,
  input  reqVec_t                  req,
  input  eboxOp_t                  eboxOp,
  input  wayStat_t [NumWays-1:0]   ways,
  input  logic     [WayW-1:0]      lru,
  input  logic                     coreDone,
  output reqVec_t                  grant,
  output logic                     readyToGo,
  output logic                     coreRdReq,
  output resp_t                    resp,
  output logic     [WayW-1:0]      respWay
);

  cycType_t  cycType;
  eboxOp_t   cycOp;
  matchSum_t sum;
  logic      sampleWays;
  logic      anyGrant;

  assign anyGrant = |grant;

  cacheArbiter arb0 (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .eboxOp    (eboxOp),
    .readyToGo (readyToGo),
    .grant     (grant),
    .cycType   (cycType),
    .cycOp     (cycOp)
  );

  wayMatch #(
    .NumWays (NumWays)
  ) match0 (
    .clk        (clk),
    .rst        (rst),
    .ways       (ways),
    .lru        (lru),
    .sampleWays (sampleWays),
    .sum        (sum),
    .way        (respWay)
  );

  cacheSequencer seq0 (
    .clk        (clk),
    .rst        (rst),
    .cycType    (cycType),
    .cycOp      (cycOp),
    .anyGrant   (anyGrant),
    .sum        (sum),
    .coreDone   (coreDone),
    .readyToGo  (readyToGo),
    .sampleWays (sampleWays),
    .coreRdReq  (coreRdReq),
    .resp       (resp)
  );

endmodule

// ==== hdl/cacheSequencer.sv ====
`timescale 1ns/1ps

module cacheSequencer
  import cachePkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  cycType_t  cycType,
  input  eboxOp_t   cycOp,
  input  logic      anyGrant,
  input  matchSum_t sum,
  input  logic      coreDone,
  output logic      readyToGo,
  output logic      sampleWays,
  output logic      coreRdReq,
  output resp_t     resp
);

  seqState_t state;
  seqState_t nextState;
  outcome_t  t3Outcome;
  logic      readMiss;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      state <= nextState;
    end
  end

  // EBOX read with no valid word in any way
  assign readMiss = (cycType == CYC_EBOX) && (cycOp == OP_READ) && !sum.rdFound;

  // Outcome decided in T3
  always_comb begin
    t3Outcome = OUT_PASS;
    case (cycType)
      CYC_EBOX: begin
        if (cycOp == OP_READ) begin
          if (sum.rdFound) begin
            t3Outcome = OUT_READ_HIT;
          end else begin
            t3Outcome = OUT_READ_FILL;
          end
        end else if (sum.anyValidMatch) begin
          t3Outcome = OUT_WRITE_HIT;
        end else if (sum.lruWritten) begin
          // Victim is dirty
          t3Outcome = OUT_WRITEBACK;
        end else begin
          t3Outcome = OUT_WRITE_ALLOC;
        end
      end
      CYC_CCA: begin
        if (!sum.anyValidMatch) begin
          t3Outcome = OUT_NO_MATCH;
        end else if (sum.matchWritten) begin
          t3Outcome = OUT_WRITEBACK;
        end else begin
          t3Outcome = OUT_INVAL;
        end
      end
      default: begin
        // MB and channel data moves elsewhere
        t3Outcome = OUT_PASS;
      end
    endcase
  end

  always_comb begin
    nextState = state;
    case (state)
      ST_IDLE: begin
        if (anyGrant) begin
          nextState = ST_T1;
        end
      end
      ST_T1: begin
        nextState = ST_T2;
      end
      ST_T2: begin
        nextState = ST_T3;
      end
      ST_T3: begin
        if (!readMiss) begin
          nextState = ST_IDLE;
        end else if (coreDone) begin
          nextState = ST_RESP;
        end else begin
          nextState = ST_CORE_WAIT;
        end
      end
      ST_CORE_WAIT: begin
        if (coreDone) begin
          nextState = ST_RESP;
        end
      end
      ST_RESP: begin
        nextState = ST_IDLE;
      end
      default: begin
        nextState = ST_IDLE;
      end
    endcase
  end

  assign readyToGo = (state == ST_IDLE);
  assign sampleWays = (state == ST_T1);

  // Core read held from T3 until memory answers
  assign coreRdReq = ((state == ST_T3) && readMiss) || (state == ST_CORE_WAIT);

  always_comb begin
    resp.valid = ((state == ST_T3) && !readMiss) || (state == ST_RESP);
    resp.cycle = cycType;
    resp.outcome = t3Outcome;
  end

endmodule

// ==== hdl/wayMatch.sv ====
`timescale 1ns/1ps

module wayMatch
  import cachePkg::*;
#(
  parameter int NumWays = 4,
  localparam int WayW = (NumWays > 1) ? $clog2(NumWays) : 1
) (
  input  logic                     clk,
  input  logic                     rst,
  input  wayStat_t [NumWays-1:0]   ways,
  input  logic     [WayW-1:0]      lru,
  input  logic                     sampleWays,
  output matchSum_t                sum,
  output logic     [WayW-1:0]      way
);

  matchSum_t        sumNext;
  logic [WayW-1:0]  pick;

  always_comb begin
    sumNext = '0;
    pick = lru;
    // Walk downward so the lowest matching way wins
    for (int i = NumWays - 1; i >= 0; i--) begin
      if (ways[i].validMatch) begin
        pick = WayW'(i);
      end
      sumNext.anyValidMatch |= ways[i].validMatch;
      sumNext.rdFound |= ways[i].validMatch & ways[i].wordValid;
    end
    sumNext.matchWritten = sumNext.anyValidMatch & ways[pick].anyWritten;
    sumNext.lruWritten = ways[lru].anyWritten;
  end

  // Sampled in T1, stable through T3
  always_ff @(posedge clk) begin
    if (rst) begin
      sum <= '0;
      way <= '0;
    end else if (sampleWays) begin
      sum <= sumNext;
      way <= pick;
    end
  end

endmodule

// ==== hdl/cacheArbiter.sv ====
`timescale 1ns/1ps

module cacheArbiter
  import cachePkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  reqVec_t  req,
  input  eboxOp_t  eboxOp,
  input  logic     readyToGo,
  output reqVec_t  grant,
  output cycType_t cycType,
  output eboxOp_t  cycOp
);

  cycType_t grantType;

  // Fixed priority: MB, channel, EBOX, then CCA
  always_comb begin
    grant = '0;
    grantType = CYC_NONE;
    if (readyToGo) begin
      if (req.mbReq) begin
        grant.mbReq = 1'b1;
        grantType = CYC_MB;
      end else if (req.chanReq) begin
        grant.chanReq = 1'b1;
        grantType = CYC_CHAN;
      end else if (req.eboxReq) begin
        grant.eboxReq = 1'b1;
        grantType = CYC_EBOX;
      end else if (req.ccaReq) begin
        grant.ccaReq = 1'b1;
        grantType = CYC_CCA;
      end
    end
  end

  // Held until the next grant
  always_ff @(posedge clk) begin
    if (rst) begin
      cycType <= CYC_NONE;
      cycOp <= OP_READ;
    end else if (|grant) begin
      cycType <= grantType;
      cycOp <= eboxOp;
    end
  end

endmodule

// ==== hdl/cachePkg.sv ====
package cachePkg;

  // Cycle type latched by the arbiter at grant
  typedef enum logic [2:0] {
    CYC_NONE,
    CYC_MB,
    CYC_CHAN,
    CYC_EBOX,
    CYC_CCA
  } cycType_t;

  typedef enum logic {
    OP_READ,
    OP_WRITE
  } eboxOp_t;

  // Result reported with resp.valid
  typedef enum logic [2:0] {
    OUT_READ_HIT,
    OUT_READ_FILL,
    OUT_WRITE_HIT,
    OUT_WRITE_ALLOC,
    OUT_WRITEBACK,
    OUT_INVAL,
    OUT_NO_MATCH,
    OUT_PASS
  } outcome_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_T1,
    ST_T2,
    ST_T3,
    ST_CORE_WAIT,
    ST_RESP
  } seqState_t;

  // Highest priority first
  typedef struct packed {
    logic mbReq;
    logic chanReq;
    logic eboxReq;
    logic ccaReq;
  } reqVec_t;

  typedef struct packed {
    logic validMatch;
    logic wordValid;
    logic anyWritten;
  } wayStat_t;

  typedef struct packed {
    logic anyValidMatch;
    logic rdFound;
    logic matchWritten;
    logic lruWritten;
  } matchSum_t;

  typedef struct packed {
    logic     valid;
    cycType_t cycle;
    outcome_t outcome;
  } resp_t;

endpackage
